/* simt_commit_pkg.sv */
// Core-wide sizes and shared types for the SIMT commit stage.
// Imported by every commit module and by the testbench.

package simt_commit_pkg;

    // warp and thread geometry
    localparam int NUM_THREADS = 4;
    localparam int XLEN        = 32;
    localparam int NUM_WARPS   = 4;
    localparam int NW_BITS     = $clog2(NUM_WARPS);

    // architectural registers
    localparam int NUM_REGS = 32;
    localparam int NR_BITS  = $clog2(NUM_REGS);

    localparam int UUID_BITS = 8;

    // execution units feeding each lane
    localparam int NUM_EX_UNITS = 3;
    localparam int EX_BITS      = $clog2(NUM_EX_UNITS);

    // retired instruction counter width
    localparam int PERF_CTR_BITS = 44;

    // order here is the arbiter input order and its tie order
    typedef enum logic [EX_BITS-1:0] {
        EX_LSU,
        EX_ALU,
        EX_SFU
    } ex_unit_e;

    // one finished instruction result from an execution unit
    typedef struct packed {
        logic [UUID_BITS-1:0]              uuid;
        logic [NW_BITS-1:0]                wid;
        logic [NUM_THREADS-1:0]            tmask;
        logic [31:0]                       pc;
        logic                              wb;
        logic [NR_BITS-1:0]                rd;
        logic [NUM_THREADS-1:0][XLEN-1:0]  data;
        logic                              sop;
        logic                              eop;
    } commit_data_t;

    // register file write request
    // wis is sized for one lane and narrower slots are zero extended
    typedef struct packed {
        logic [UUID_BITS-1:0]              uuid;
        logic [NW_BITS-1:0]                wis;
        logic [NUM_THREADS-1:0]            tmask;
        logic [31:0]                       pc;
        logic [NR_BITS-1:0]                rd;
        logic [NUM_THREADS-1:0][XLEN-1:0]  data;
        logic                              sop;
        logic                              eop;
    } writeback_data_t;

endpackage

/* commit_arb.sv */
// Per-lane round-robin arbiter over the execution unit results.
// Grants one valid unit per cycle, raises ready only for that unit
// and holds the granted result in an output register for one cycle.
// The downstream side is always ready.

module commit_arb (
    input  logic                                               clk,
    input  logic                                               reset,
    input  logic [simt_commit_pkg::NUM_EX_UNITS-1:0]           unit_valid,
    input  simt_commit_pkg::commit_data_t [simt_commit_pkg::NUM_EX_UNITS-1:0] unit_data,
    output logic [simt_commit_pkg::NUM_EX_UNITS-1:0]           unit_ready,
    output logic                                               commit_valid,
    output simt_commit_pkg::commit_data_t                      commit_data
);
    import simt_commit_pkg::*;

    // unit that gets first look in the next arbitration
    ex_unit_e ptr;

    logic     grant_any;
    ex_unit_e grant_sel;

    // unit found offset steps after base, wrapping around
    function automatic ex_unit_e unit_at(ex_unit_e base, int unsigned offset);
        int unsigned pos;
        pos = int'(base) + offset;
        if (pos >= NUM_EX_UNITS) begin
            pos = pos - NUM_EX_UNITS;
        end
        return ex_unit_e'(pos);
    endfunction

    // first valid unit at or after the pointer
    always_comb begin
        grant_any = 1'b0;
        grant_sel = ptr;
        for (int k = 0; k < NUM_EX_UNITS; k++) begin
            if (!grant_any && unit_valid[unit_at(ptr, k)]) begin
                grant_any = 1'b1;
                grant_sel = unit_at(ptr, k);
            end
        end
    end

    // losers see ready low and keep their data
    always_comb begin
        unit_ready = '0;
        if (grant_any) begin
            unit_ready[grant_sel] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ptr <= EX_LSU;
        end else if (grant_any) begin
            ptr <= unit_at(grant_sel, 1);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            commit_valid <= 1'b0;
        end else begin
            commit_valid <= grant_any;
        end
    end

    // payload only moves on a grant
    always_ff @(posedge clk) begin
        if (grant_any) begin
            commit_data <= unit_data[grant_sel];
        end
    end

endmodule

/* commit_retire_count.sv */
// Retired instruction counter for the commit stage.
// Counts active threads of every valid commit across all lanes.
// Stage 1 registers per-lane popcounts, stage 2 their sum,
// and instret accumulates the sum one edge later.

module commit_retire_count #(
    parameter int ISSUE_CNT = 2
) (
    input  logic                                                   clk,
    input  logic                                                   reset,
    input  logic [ISSUE_CNT-1:0]                                   commit_valid,
    input  logic [ISSUE_CNT-1:0][simt_commit_pkg::NUM_THREADS-1:0] commit_tmask,
    output logic [simt_commit_pkg::PERF_CTR_BITS-1:0]              instret
);
    import simt_commit_pkg::*;

    // per-lane count can reach NUM_THREADS
    localparam int CNT_BITS = $clog2(NUM_THREADS + 1);
    localparam int SUM_BITS = CNT_BITS + $clog2(ISSUE_CNT);

    logic [ISSUE_CNT-1:0][CNT_BITS-1:0] lane_size;
    logic [ISSUE_CNT-1:0][CNT_BITS-1:0] lane_size_r;
    logic                               any_valid_r;
    logic [SUM_BITS-1:0]                size_sum;
    logic [SUM_BITS-1:0]                size_sum_r;
    logic                               any_valid_rr;

    // popcount of active threads, zero when the lane is idle
    always_comb begin
        for (int i = 0; i < ISSUE_CNT; i++) begin
            lane_size[i] = '0;
            if (commit_valid[i]) begin
                for (int t = 0; t < NUM_THREADS; t++) begin
                    lane_size[i] = lane_size[i] + CNT_BITS'(commit_tmask[i][t]);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            any_valid_r <= 1'b0;
        end else begin
            any_valid_r <= |commit_valid;
        end
    end

    always_ff @(posedge clk) begin
        lane_size_r <= lane_size;
    end

    // sum over lanes
    always_comb begin
        size_sum = '0;
        for (int i = 0; i < ISSUE_CNT; i++) begin
            size_sum = size_sum + SUM_BITS'(lane_size_r[i]);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            any_valid_rr <= 1'b0;
        end else begin
            any_valid_rr <= any_valid_r;
        end
    end

    always_ff @(posedge clk) begin
        size_sum_r <= size_sum;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            instret <= '0;
        end else if (any_valid_rr) begin
            instret <= instret + PERF_CTR_BITS'(size_sum_r);
        end
    end

endmodule

/* commit_writeback.sv */
// Writeback forming and scheduler notification for the commit stage.
// wb_valid follows the arbiter register directly, the committed pulse
// is registered one cycle later. Lane 0 writes also land in a
// register shadow used by simulation for end-of-test checks.

module commit_writeback #(
    parameter int ISSUE_CNT = 2,
    parameter int WIS_BITS  = 1
) (
    input  logic                                                      clk,
    input  logic                                                      reset,
    input  logic [ISSUE_CNT-1:0]                                      commit_valid,
    input  simt_commit_pkg::commit_data_t [ISSUE_CNT-1:0]             commit_data,
    output logic [ISSUE_CNT-1:0]                                      wb_valid,
    output simt_commit_pkg::writeback_data_t [ISSUE_CNT-1:0]          wb_data,
    output logic [ISSUE_CNT-1:0]                                      committed,
    output logic [ISSUE_CNT-1:0][simt_commit_pkg::NW_BITS-1:0]        committed_wid,
    output logic [simt_commit_pkg::NUM_REGS-1:0][simt_commit_pkg::XLEN-1:0] sim_wb_value
);
    import simt_commit_pkg::*;

    // warps are striped across lanes by their low id bits
    localparam int LANE_BITS = $clog2(ISSUE_CNT);

    for (genvar i = 0; i < ISSUE_CNT; i++) begin : g_lane
        assign wb_valid[i]      = commit_valid[i] && commit_data[i].wb;
        assign wb_data[i].uuid  = commit_data[i].uuid;
        assign wb_data[i].wis   = NW_BITS'(WIS_BITS'(commit_data[i].wid >> LANE_BITS));
        assign wb_data[i].tmask = commit_data[i].tmask;
        assign wb_data[i].pc    = commit_data[i].pc;
        assign wb_data[i].rd    = commit_data[i].rd;
        assign wb_data[i].data  = commit_data[i].data;
        assign wb_data[i].sop   = commit_data[i].sop;
        assign wb_data[i].eop   = commit_data[i].eop;
    end

    // last piece of an instruction tells the scheduler the warp is done
    always_ff @(posedge clk) begin
        if (reset) begin
            committed <= '0;
        end else begin
            for (int i = 0; i < ISSUE_CNT; i++) begin
                committed[i] <= commit_valid[i] && commit_data[i].eop;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < ISSUE_CNT; i++) begin
            committed_wid[i] <= commit_data[i].wid;
        end
    end

    // thread 0 value of each lane 0 register write
    always_ff @(posedge clk) begin
        if (wb_valid[0]) begin
            sim_wb_value[commit_data[0].rd] <= commit_data[0].data[0];
        end
    end

endmodule

/* simt_commit.sv */
// Top level of the SIMT commit stage.
// One round-robin arbiter per issue lane picks among the LSU, ALU
// and SFU results; the chosen commits feed the writeback block and
// the retired instruction counter. ISSUE_CNT may be 1, 2 or 4.

module simt_commit #(
    parameter int ISSUE_CNT = 2
) (
    input  logic                                                   clk,
    input  logic                                                   reset,
    input  logic [ISSUE_CNT-1:0][simt_commit_pkg::NUM_EX_UNITS-1:0] unit_valid,
    input  simt_commit_pkg::commit_data_t
               [ISSUE_CNT-1:0][simt_commit_pkg::NUM_EX_UNITS-1:0]  unit_data,
    output logic [ISSUE_CNT-1:0][simt_commit_pkg::NUM_EX_UNITS-1:0] unit_ready,
    output logic [ISSUE_CNT-1:0]                                   wb_valid,
    output simt_commit_pkg::writeback_data_t [ISSUE_CNT-1:0]       wb_data,
    output logic [ISSUE_CNT-1:0]                                   committed,
    output logic [ISSUE_CNT-1:0][simt_commit_pkg::NW_BITS-1:0]     committed_wid,
    output logic [simt_commit_pkg::PERF_CTR_BITS-1:0]              instret,
    output logic [simt_commit_pkg::NUM_REGS-1:0][simt_commit_pkg::XLEN-1:0] sim_wb_value
);
    import simt_commit_pkg::*;

    // warp slots per lane, at least one bit even with one warp per lane
    localparam int WIS_BITS = (ISSUE_CNT >= NUM_WARPS) ? 1 : NW_BITS - $clog2(ISSUE_CNT);

    logic [ISSUE_CNT-1:0]                  commit_valid;
    commit_data_t [ISSUE_CNT-1:0]          commit_data;
    logic [ISSUE_CNT-1:0][NUM_THREADS-1:0] commit_tmask;

    for (genvar i = 0; i < ISSUE_CNT; i++) begin : g_arb
        commit_arb i_commit_arb (
            .clk          (clk),
            .reset        (reset),
            .unit_valid   (unit_valid[i]),
            .unit_data    (unit_data[i]),
            .unit_ready   (unit_ready[i]),
            .commit_valid (commit_valid[i]),
            .commit_data  (commit_data[i])
        );

        assign commit_tmask[i] = commit_data[i].tmask;
    end

    commit_retire_count #(
        .ISSUE_CNT (ISSUE_CNT)
    ) i_commit_retire_count (
        .clk          (clk),
        .reset        (reset),
        .commit_valid (commit_valid),
        .commit_tmask (commit_tmask),
        .instret      (instret)
    );

    commit_writeback #(
        .ISSUE_CNT (ISSUE_CNT),
        .WIS_BITS  (WIS_BITS)
    ) i_commit_writeback (
        .clk           (clk),
        .reset         (reset),
        .commit_valid  (commit_valid),
        .commit_data   (commit_data),
        .wb_valid      (wb_valid),
        .wb_data       (wb_data),
        .committed     (committed),
        .committed_wid (committed_wid),
        .sim_wb_value  (sim_wb_value)
    );

endmodule

/* simt_commit_assert.sv */
// Concurrent checks on the commit stage, bound into the top level.
// Covers the unit handshake, the writeback qualifier and the
// committed pulse coming out of reset.

module simt_commit_assert #(
    parameter int ISSUE_CNT = 2
) (
    input logic                                                   clk,
    input logic                                                   reset,
    input logic [ISSUE_CNT-1:0][simt_commit_pkg::NUM_EX_UNITS-1:0] unit_valid,
    input simt_commit_pkg::commit_data_t
              [ISSUE_CNT-1:0][simt_commit_pkg::NUM_EX_UNITS-1:0]  unit_data,
    input logic [ISSUE_CNT-1:0][simt_commit_pkg::NUM_EX_UNITS-1:0] unit_ready,
    input logic [ISSUE_CNT-1:0]                                   commit_valid,
    input logic [ISSUE_CNT-1:0]                                   wb_valid,
    input logic [ISSUE_CNT-1:0]                                   committed
);
    import simt_commit_pkg::*;

    // sticky once any property below fails
    bit assert_failed = 1'b0;

    // no stale pulse reaches the scheduler after reset
    a_committed_reset: assert property (@(posedge clk) reset |=> committed == '0)
        else begin
            assert_failed = 1'b1;
            $error("committed is high in the cycle after reset");
        end

    for (genvar i = 0; i < ISSUE_CNT; i++) begin : g_lane
        a_ready_onehot: assert property (@(posedge clk) disable iff (reset)
            $onehot0(unit_ready[i]))
            else begin
                assert_failed = 1'b1;
                $error("unit_ready of lane %0d grants more than one unit", i);
            end

        a_wb_valid: assert property (@(posedge clk) disable iff (reset)
            wb_valid[i] |-> commit_valid[i])
            else begin
                assert_failed = 1'b1;
                $error("wb_valid of lane %0d without commit_valid", i);
            end

        // a waiting unit keeps its result until granted
        for (genvar u = 0; u < NUM_EX_UNITS; u++) begin : g_unit
            a_hold: assert property (@(posedge clk) disable iff (reset)
                unit_valid[i][u] && !unit_ready[i][u]
                |=> unit_valid[i][u] && $stable(unit_data[i][u]))
                else begin
                    assert_failed = 1'b1;
                    $error("unit %0d of lane %0d dropped or changed its result", u, i);
                end
        end
    end

endmodule

bind simt_commit simt_commit_assert #(
    .ISSUE_CNT (ISSUE_CNT)
) i_simt_commit_assert (
    .clk          (clk),
    .reset        (reset),
    .unit_valid   (unit_valid),
    .unit_data    (unit_data),
    .unit_ready   (unit_ready),
    .commit_valid (commit_valid),
    .wb_valid     (wb_valid),
    .committed    (committed)
);

/* simt_commit_tb.sv */
// Testbench for the SIMT commit stage.
// Offers a table of unit results per cycle to both lanes, models the
// round-robin grants and checks ready, writeback, committed pulses,
// instret and the lane 0 register shadow against that model.

module simt_commit_tb;
    import simt_commit_pkg::*;

    localparam int ISSUE_CNT = 2;
    localparam int NUM_ROWS  = 48;
    localparam int HAND_ROWS = 12;
    localparam int DRAIN     = 8;
    localparam int TIMEOUT   = NUM_ROWS + 20;

    // one table entry for one unit of one lane
    typedef struct packed {
        logic                   valid;
        logic [NUM_THREADS-1:0] tmask;
        logic                   wb;
        logic [NR_BITS-1:0]     rd;
        logic                   eop;
        logic [7:0]             seed;
    } stim_t;

    logic                                           clk;
    logic                                           reset;
    logic [ISSUE_CNT-1:0][NUM_EX_UNITS-1:0]         unit_valid;
    commit_data_t [ISSUE_CNT-1:0][NUM_EX_UNITS-1:0] unit_data;
    logic [ISSUE_CNT-1:0][NUM_EX_UNITS-1:0]         unit_ready;
    logic [ISSUE_CNT-1:0]                           wb_valid;
    writeback_data_t [ISSUE_CNT-1:0]                wb_data;
    logic [ISSUE_CNT-1:0]                           committed;
    logic [ISSUE_CNT-1:0][NW_BITS-1:0]              committed_wid;
    logic [PERF_CTR_BITS-1:0]                       instret;
    logic [NUM_REGS-1:0][XLEN-1:0]                  sim_wb_value;

    stim_t                                  stim [NUM_ROWS][ISSUE_CNT][NUM_EX_UNITS];
    commit_data_t                           pending [ISSUE_CNT][NUM_EX_UNITS][$];
    logic [ISSUE_CNT-1:0][NUM_EX_UNITS-1:0] xfer;
    int                                     uuid_next;
    int                                     cycle_cnt;

    // reference model state
    int              exp_ptr [ISSUE_CNT];
    logic            cur_valid [ISSUE_CNT];
    commit_data_t    cur_data [ISSUE_CNT];
    logic            prev_valid [ISSUE_CNT];
    commit_data_t    prev_data [ISSUE_CNT];
    int              exp_commits [ISSUE_CNT][NUM_WARPS];
    int              obs_commits [ISSUE_CNT][NUM_WARPS];
    logic [XLEN-1:0] exp_shadow [NUM_REGS];
    logic            shadow_written [NUM_REGS];
    longint          exp_instret;

    simt_commit #(
        .ISSUE_CNT (ISSUE_CNT)
    ) i_dut (
        .clk           (clk),
        .reset         (reset),
        .unit_valid    (unit_valid),
        .unit_data     (unit_data),
        .unit_ready    (unit_ready),
        .wb_valid      (wb_valid),
        .wb_data       (wb_data),
        .committed     (committed),
        .committed_wid (committed_wid),
        .instret       (instret),
        .sim_wb_value  (sim_wb_value)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        if (reset) begin
            cycle_cnt <= 0;
        end else begin
            cycle_cnt <= cycle_cnt + 1;
            if (cycle_cnt >= TIMEOUT) begin
                $display("Error: timeout, the test did not finish within %0d cycles", TIMEOUT);
                report_failure();
            end
        end
    end

    task automatic report_failure();
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(string name, logic [255:0] exp, logic [255:0] act);
        assert (act === exp) else begin
            $display("Error at %0t: %s expected %0h, got %0h", $time, name, exp, act);
            report_failure();
        end
    endtask

    function automatic commit_data_t make_result(stim_t s, int row, int lane, int unit, int uuid);
        commit_data_t d;
        d.uuid  = UUID_BITS'(uuid);
        d.wid   = s.seed[NW_BITS-1:0];
        d.tmask = s.tmask;
        d.pc    = 32'h1000 + 32'(row * 16 + lane * 4 + unit);
        d.wb    = s.wb;
        d.rd    = s.rd;
        for (int t = 0; t < NUM_THREADS; t++) begin
            d.data[t] = {s.seed, 8'(row), 4'(lane), 4'(unit), 8'(t)};
        end
        d.sop = 1'b1;
        d.eop = s.eop;
        return d;
    endfunction

    // warp slot is the warp id divided by the lane count
    function automatic writeback_data_t expected_writeback(commit_data_t d);
        writeback_data_t w;
        w.uuid  = d.uuid;
        w.wis   = NW_BITS'(d.wid / ISSUE_CNT);
        w.tmask = d.tmask;
        w.pc    = d.pc;
        w.rd    = d.rd;
        w.data  = d.data;
        w.sop   = d.sop;
        w.eop   = d.eop;
        return w;
    endfunction

    function automatic bit units_busy();
        for (int l = 0; l < ISSUE_CNT; l++) begin
            for (int u = 0; u < NUM_EX_UNITS; u++) begin
                if (pending[l][u].size() != 0) begin
                    return 1'b1;
                end
            end
        end
        return 1'b0;
    endfunction

    task automatic fill_table();
        stim_t s;
        int    u;
        for (int row = 0; row < NUM_ROWS; row++) begin
            for (int l = 0; l < ISSUE_CNT; l++) begin
                for (int k = 0; k < NUM_EX_UNITS; k++) begin
                    stim[row][l][k] = '0;
                end
            end
        end
        // lone results rotating over the units
        // rows 2 and 5 carry no writeback
        for (int row = 0; row < 6; row++) begin
            for (int l = 0; l < ISSUE_CNT; l++) begin
                s       = '0;
                s.valid = 1'b1;
                s.tmask = NUM_THREADS'(row + 1);
                s.wb    = (row % 3 != 2);
                s.rd    = NR_BITS'(row + 1);
                s.eop   = (row % 2 == 0);
                s.seed  = 8'(row * 7 + l);
                stim[row][l][(row + l) % NUM_EX_UNITS] = s;
            end
        end
        // all units of both lanes at once
        // every lane 0 write goes to r10
        for (int row = 6; row < HAND_ROWS; row += 3) begin
            for (int l = 0; l < ISSUE_CNT; l++) begin
                for (int k = 0; k < NUM_EX_UNITS; k++) begin
                    s       = '0;
                    s.valid = 1'b1;
                    s.tmask = NUM_THREADS'(4'hf >> k);
                    s.wb    = 1'b1;
                    s.rd    = NR_BITS'(10);
                    s.eop   = 1'b1;
                    s.seed  = 8'(row * 16 + l * 4 + k);
                    stim[row][l][k] = s;
                end
            end
        end
        // random traffic with at most one unit per lane and row
        for (int row = HAND_ROWS; row < NUM_ROWS; row++) begin
            for (int l = 0; l < ISSUE_CNT; l++) begin
                if ($urandom % 4 != 0) begin
                    s.valid = 1'b1;
                    s.tmask = NUM_THREADS'($urandom);
                    s.wb    = 1'($urandom);
                    s.rd    = NR_BITS'($urandom);
                    s.eop   = 1'($urandom);
                    s.seed  = 8'($urandom);
                    u       = int'($urandom % NUM_EX_UNITS);
                    stim[row][l][u] = s;
                end
            end
        end
    endtask

    task automatic record_transfer(int lane, commit_data_t d);
        cur_valid[lane] = 1'b1;
        cur_data[lane]  = d;
        exp_instret     = exp_instret + $countones(d.tmask);
        if (d.eop) begin
            exp_commits[lane][d.wid]++;
        end
        if (lane == 0 && d.wb) begin
            exp_shadow[d.rd]     = d.data[0];
            shadow_written[d.rd] = 1'b1;
        end
    endtask

    // wb follows a transfer by one cycle and committed by two
    task automatic check_outputs();
        assert (!i_dut.i_simt_commit_assert.assert_failed) else begin
            $display("Error at %0t: a bound handshake or reset property failed", $time);
            report_failure();
        end
        for (int l = 0; l < ISSUE_CNT; l++) begin
            check_value($sformatf("wb_valid[%0d]", l),
                        256'(cur_valid[l] && cur_data[l].wb), 256'(wb_valid[l]));
            if (cur_valid[l] && cur_data[l].wb) begin
                check_value($sformatf("wb_data[%0d]", l),
                            256'(expected_writeback(cur_data[l])), 256'(wb_data[l]));
            end
            check_value($sformatf("committed[%0d]", l),
                        256'(prev_valid[l] && prev_data[l].eop), 256'(committed[l]));
            if (committed[l]) begin
                check_value($sformatf("committed_wid[%0d]", l),
                            256'(prev_data[l].wid), 256'(committed_wid[l]));
                obs_commits[l][committed_wid[l]]++;
            end
            prev_valid[l] = cur_valid[l];
            prev_data[l]  = cur_data[l];
            cur_valid[l]  = 1'b0;
        end
    endtask

    task automatic run_cycle(int row, bit use_row);
        int                      gsel;
        int                      cand;
        logic [NUM_EX_UNITS-1:0] exp_ready;
        @(negedge clk);
        check_outputs();
        for (int l = 0; l < ISSUE_CNT; l++) begin
            for (int u = 0; u < NUM_EX_UNITS; u++) begin
                if (xfer[l][u]) begin
                    void'(pending[l][u].pop_front());
                end
                if (use_row && stim[row][l][u].valid) begin
                    pending[l][u].push_back(make_result(stim[row][l][u], row, l, u, uuid_next));
                    uuid_next++;
                end
                unit_valid[l][u] = (pending[l][u].size() != 0);
                unit_data[l][u]  = (pending[l][u].size() != 0) ? pending[l][u][0] : '0;
            end
        end
        #5;
        // grant is the first valid unit at or after the model pointer
        for (int l = 0; l < ISSUE_CNT; l++) begin
            gsel = -1;
            for (int k = 0; k < NUM_EX_UNITS; k++) begin
                cand = (exp_ptr[l] + k) % NUM_EX_UNITS;
                if (gsel < 0 && unit_valid[l][cand]) begin
                    gsel = cand;
                end
            end
            exp_ready = '0;
            if (gsel >= 0) begin
                exp_ready[gsel] = 1'b1;
            end
            check_value($sformatf("unit_ready[%0d]", l), 256'(exp_ready), 256'(unit_ready[l]));
            xfer[l] = exp_ready;
            if (gsel >= 0) begin
                record_transfer(l, pending[l][gsel][0]);
                exp_ptr[l] = (gsel + 1) % NUM_EX_UNITS;
            end
        end
    endtask

    initial begin
        void'($urandom(3014));
        reset       = 1'b1;
        unit_valid  = '0;
        unit_data   = '0;
        xfer        = '0;
        uuid_next   = 0;
        exp_instret = 0;
        for (int l = 0; l < ISSUE_CNT; l++) begin
            exp_ptr[l]    = 0;
            cur_valid[l]  = 1'b0;
            cur_data[l]   = '0;
            prev_valid[l] = 1'b0;
            prev_data[l]  = '0;
            for (int w = 0; w < NUM_WARPS; w++) begin
                exp_commits[l][w] = 0;
                obs_commits[l][w] = 0;
            end
        end
        for (int r = 0; r < NUM_REGS; r++) begin
            exp_shadow[r]     = '0;
            shadow_written[r] = 1'b0;
        end
        fill_table();

        repeat (5) @(negedge clk);
        reset = 1'b0;
        // pipeline comes out of reset empty
        check_value("wb_valid", 256'(0), 256'(wb_valid));
        check_value("committed", 256'(0), 256'(committed));
        check_value("instret", 256'(0), 256'(instret));

        for (int row = 0; row < NUM_ROWS; row++) begin
            run_cycle(row, 1'b1);
        end
        while (units_busy()) begin
            run_cycle(0, 1'b0);
        end
        repeat (DRAIN) run_cycle(0, 1'b0);

        for (int r = 0; r < NUM_REGS; r++) begin
            if (shadow_written[r]) begin
                check_value($sformatf("sim_wb_value[%0d]", r),
                            256'(exp_shadow[r]), 256'(sim_wb_value[r]));
            end
        end
        check_value("instret", 256'(exp_instret), 256'(instret));
        for (int l = 0; l < ISSUE_CNT; l++) begin
            for (int w = 0; w < NUM_WARPS; w++) begin
                check_value($sformatf("committed count lane %0d warp %0d", l, w),
                            256'(exp_commits[l][w]), 256'(obs_commits[l][w]));
            end
        end

        $display("RESULT: PASS");
        $finish;
    end

endmodule

/* simt_commit.f */
simt_commit_pkg.sv
commit_arb.sv
commit_retire_count.sv
commit_writeback.sv
simt_commit.sv
simt_commit_assert.sv
simt_commit_tb.sv

/* Bender.yml */
package:
  name: simt_commit

sources:
  - files:
      - simt_commit_pkg.sv
      - commit_arb.sv
      - commit_retire_count.sv
      - commit_writeback.sv
      - simt_commit.sv
  - target: test
    files:
      - simt_commit_assert.sv
      - simt_commit_tb.sv
